//--- flist.f
+incdir+verilog
+incdir+sim
verilog/exu_pkg.sv
verilog/csr_pkg.sv
verilog/exu_stage_reg.sv
verilog/exu_operand_sel.sv
verilog/exu_alu.sv
verilog/exu_branch_unit.sv
verilog/exu_csr_ctrl.sv
verilog/exu_top.sv
sim/exu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f flist.f --top-module exu_tb -Mdir obj_dir -o exu_tb_sim

./obj_dir/exu_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
echo "simulation passed"

//--- sim/exu_tb_vectors.svh
`ifndef EXU_TB_VECTORS_SVH
`define EXU_TB_VECTORS_SVH

// columns: opcode, inst, pc, src_a, src_b, imm,
//   then expected alu_out, dnpc, pc_update, csr wen {mtvec,mepc,mcause,mstatus},
//   data on the enabled csr, data on mcause

task automatic load_table();
    // register alu ops
    add_row(`OPC_ADD,   0, 'h1000, 5, 7, 0, 12, 'h1004, 0, 0, 0, 0);
    add_row(`OPC_SUB,   0, 'h1004, 5, 7, 0, -64'd2, 'h1008, 0, 0, 0, 0);
    // shift amount uses only the low 6 bits of src_b
    add_row(`OPC_SLL,   0, 'h1008, 3, 'h44, 0, 48, 'h100c, 0, 0, 0, 0);
    add_row(`OPC_SRL,   0, 'h100c, 'hff00, 72, 0, 'hff, 'h1010, 0, 0, 0, 0);
    add_row(`OPC_SLT,   0, 'h1010, -64'd1, 1, 0, 1, 'h1014, 0, 0, 0, 0);
    add_row(`OPC_SLTU,  0, 'h1014, -64'd1, 1, 0, 0, 'h1018, 0, 0, 0, 0);
    add_row(`OPC_XOR,   0, 'h1018, 'hf0f0, 'hff00, 0, 'h0ff0, 'h101c, 0, 0, 0, 0);
    add_row(`OPC_OR,    0, 'h101c, 'hf0f0, 'h0f0f, 0, 'hffff, 'h1020, 0, 0, 0, 0);
    add_row(`OPC_AND,   0, 'h1020, 'hf0f0, 'h3c3c, 0, 'h3030, 'h1024, 0, 0, 0, 0);
    // immediate and upper immediate forms
    add_row(`OPC_ADDI,  0, 'h1024, 100, 0, -64'd30, 70, 'h1028, 0, 0, 0, 0);
    add_row(`OPC_LUI,   0, 'h1028, 99, 0, 'h12345000, 'h12345000, 'h102c, 0, 0, 0, 0);
    add_row(`OPC_AUIPC, 0, 'h102c, 0, 0, 'h2000, 'h302c, 'h1030, 0, 0, 0, 0);
    // word ops, result sign-extended from bit 31
    add_row(`OPC_ADDW,  0, 'h1030, 'h7fff_ffff, 1, 0, 64'hffff_ffff_8000_0000, 'h1034,
            0, 0, 0, 0);
    add_row(`OPC_SUBW,  0, 'h1034, 64'h5_0000_0003, 5, 0, -64'd2, 'h1038, 0, 0, 0, 0);
    // sraiw shamt sits in inst[24:20]
    add_row(`OPC_SRAIW, 'h0040_0000, 'h1038, 'h8000_0010, 0, 0, 64'hffff_ffff_f800_0001,
            'h103c, 0, 0, 0, 0);
    add_row(`OPC_SRAIW, 'h0080_0000, 'h103c, 64'hffff_ffff_7000_0000, 0, 0, 'h0070_0000,
            'h1040, 0, 0, 0, 0);
    // jumps
    add_row(`OPC_JAL,   0, 'h2000, 0, 0, 'h100, 'h2100, 'h2100, 1, 0, 0, 0);
    add_row(`OPC_JALR,  0, 'h2004, 'h3001, 0, 'h10, 'h3011, 'h3010, 1, 0, 0, 0);
    // branches, taken row then not-taken row
    add_row(`OPC_BEQ,   0, 'h3000, 7, 7, 'h40, 'h3040, 'h3040, 1, 0, 0, 0);
    add_row(`OPC_BEQ,   0, 'h3004, 7, 8, 'h40, 'h3044, 'h3008, 1, 0, 0, 0);
    add_row(`OPC_BNE,   0, 'h3008, 7, 8, -64'd8, 'h3000, 'h3000, 1, 0, 0, 0);
    add_row(`OPC_BNE,   0, 'h300c, 7, 7, -64'd8, 'h3004, 'h3010, 1, 0, 0, 0);
    add_row(`OPC_BLT,   0, 'h3010, -64'd5, 3, 'h20, 'h3030, 'h3030, 1, 0, 0, 0);
    add_row(`OPC_BLT,   0, 'h3014, 3, -64'd5, 'h20, 'h3034, 'h3018, 1, 0, 0, 0);
    add_row(`OPC_BGE,   0, 'h3018, 3, -64'd5, 'h20, 'h3038, 'h3038, 1, 0, 0, 0);
    add_row(`OPC_BGE,   0, 'h301c, -64'd5, 3, 'h20, 'h303c, 'h3020, 1, 0, 0, 0);
    // unsigned compare sees -5 as a huge value
    add_row(`OPC_BLTU,  0, 'h3020, 3, -64'd5, 'h20, 'h3040, 'h3040, 1, 0, 0, 0);
    add_row(`OPC_BLTU,  0, 'h3024, -64'd5, 3, 'h20, 'h3044, 'h3028, 1, 0, 0, 0);
    add_row(`OPC_BGEU,  0, 'h3028, -64'd5, 3, 'h20, 'h3048, 'h3048, 1, 0, 0, 0);
    add_row(`OPC_BGEU,  0, 'h302c, 3, -64'd5, 'h20, 'h304c, 'h3030, 1, 0, 0, 0);
    // csr number in inst[31:20], old csr value on src_b
    add_row(`OPC_CSRRW, 'h3050_0000, 'h4000, 'h8000_0100, 'h55, 0, 'h8000_0155, 'h4004,
            0, 'b1000, 'h8000_0100, 0);
    add_row(`OPC_CSRRS, 'h3000_0000, 'h4004, 8, 'h1800, 0, 'h1808, 'h4008,
            0, 'b0001, 'h1808, 0);
    add_row(`OPC_CSRRW, 'h3410_0000, 'h4008, 'h1234, 0, 0, 'h1234, 'h400c,
            0, 'b0100, 'h1234, 0);
    add_row(`OPC_CSRRS, 'h3420_0000, 'h400c, 3, 8, 0, 'hb, 'h4010, 0, 'b0010, 0, 'hb);
    // mscratch, none of the four
    add_row(`OPC_CSRRW, 'h3400_0000, 'h4010, 'h77, 0, 0, 'h77, 'h4014, 0, 0, 0, 0);
    // trap entry and return, target arrives on src_b
    add_row(`OPC_ECALL, 0, 'h5000, 0, 'h8000_0100, 0, 'h8000_0100, 'h8000_0100,
            1, 'b0110, 'h5000, 11);
    add_row(`OPC_MRET,  0, 'h6000, 0, 'h5004, 0, 'h5004, 'h5004, 1, 0, 0, 0);
endtask

`endif

//--- sim/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_tb;

    // cycles any single wait may take
    localparam int WAIT_LIMIT = 20;

    // table row holds stimulus then expected values
    typedef struct packed {
        exu_pkg::opcode_t op;
        exu_pkg::inst_t   inst;
        exu_pkg::xlen_t   pc;
        exu_pkg::xlen_t   src_a;
        exu_pkg::xlen_t   src_b;
        exu_pkg::xlen_t   imm;
        exu_pkg::xlen_t   alu;
        exu_pkg::xlen_t   dnpc;
        logic             pcu;
        // mtvec, mepc, mcause, mstatus from msb down
        logic [3:0]       wen;
        exu_pkg::xlen_t   wd;
        exu_pkg::xlen_t   cause;
    } row_t;

    logic clk;
    logic rst;
    logic valid_in;
    logic ready_in;
    logic ready_out;
    logic valid_out;
    logic pc_update;
    logic mtvec_wen;
    logic mepc_wen;
    logic mcause_wen;
    logic mstatus_wen;
    exu_pkg::xlen_t     pc_in;
    exu_pkg::inst_t     inst_in;
    exu_pkg::opcode_t   opcode_in;
    exu_pkg::xlen_t     src_a;
    exu_pkg::xlen_t     src_b;
    exu_pkg::xlen_t     imm;
    exu_pkg::xlen_t     pc_out;
    exu_pkg::inst_t     inst_out;
    exu_pkg::opcode_t   opcode_out;
    exu_pkg::xlen_t     alu_out;
    exu_pkg::xlen_t     src_b_out;
    exu_pkg::xlen_t     dnpc;
    csr_pkg::csr_data_t mtvec_wdata;
    csr_pkg::csr_data_t mepc_wdata;
    csr_pkg::csr_data_t mcause_wdata;
    csr_pkg::csr_data_t mstatus_wdata;

    row_t        rows[$];
    int          errors;
    // live outputs and the copy taken when a stall starts
    logic [63:0] cur [16];
    logic [63:0] held [16];
    string       out_name [16];

    exu_top dut0 (
        .clk(clk), .rst(rst),
        .valid_in(valid_in), .ready_in(ready_in), .pc_in(pc_in), .inst_in(inst_in),
        .opcode_in(opcode_in), .src_a(src_a), .src_b(src_b), .imm(imm),
        .valid_out(valid_out), .ready_out(ready_out), .pc_out(pc_out),
        .inst_out(inst_out), .opcode_out(opcode_out), .alu_out(alu_out),
        .src_b_out(src_b_out), .dnpc(dnpc), .pc_update(pc_update),
        .mtvec_wen(mtvec_wen), .mepc_wen(mepc_wen), .mcause_wen(mcause_wen),
        .mstatus_wen(mstatus_wen), .mtvec_wdata(mtvec_wdata), .mepc_wdata(mepc_wdata),
        .mcause_wdata(mcause_wdata), .mstatus_wdata(mstatus_wdata)
    );

    always_comb begin
        cur[0]  = 64'(valid_out);
        cur[1]  = pc_out;
        cur[2]  = 64'(inst_out);
        cur[3]  = 64'(opcode_out);
        cur[4]  = alu_out;
        cur[5]  = src_b_out;
        cur[6]  = dnpc;
        cur[7]  = 64'(pc_update);
        cur[8]  = 64'(mtvec_wen);
        cur[9]  = 64'(mepc_wen);
        cur[10] = 64'(mcause_wen);
        cur[11] = 64'(mstatus_wen);
        cur[12] = mtvec_wdata;
        cur[13] = mepc_wdata;
        cur[14] = mcause_wdata;
        cur[15] = mstatus_wdata;
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout, no %s within %0d cycles", what, WAIT_LIMIT);
        abort_run();
    endtask

    task automatic add_row(input exu_pkg::opcode_t op, input exu_pkg::inst_t inst,
                           input exu_pkg::xlen_t pc_v, input exu_pkg::xlen_t a,
                           input exu_pkg::xlen_t b, input exu_pkg::xlen_t im,
                           input exu_pkg::xlen_t alu, input exu_pkg::xlen_t npc,
                           input int pcu, input int wen,
                           input exu_pkg::xlen_t wd, input exu_pkg::xlen_t cause);
        rows.push_back(row_t'({op, inst, pc_v, a, b, im, alu, npc, pcu[0], wen[3:0], wd, cause}));
    endtask

    `include "exu_tb_vectors.svh"

    task automatic drive_row(input row_t r);
        valid_in  = 1'b1;
        ready_out = 1'b1;
        pc_in     = r.pc;
        inst_in   = r.inst;
        opcode_in = r.op;
        src_a     = r.src_a;
        src_b     = r.src_b;
        imm       = r.imm;
    endtask

    // pc and opcode also prove the row was neither dropped nor doubled
    task automatic check_row(input row_t r);
        check("pc_out", pc_out, r.pc);
        check("opcode_out", 64'(opcode_out), 64'(r.op));
        check("inst_out", 64'(inst_out), 64'(r.inst));
        check("src_b_out", src_b_out, r.src_b);
        check("alu_out", alu_out, r.alu);
        check("dnpc", dnpc, r.dnpc);
        check("pc_update", 64'(pc_update), 64'(r.pcu));
        check("mtvec_wen", 64'(mtvec_wen), 64'(r.wen[3]));
        check("mepc_wen", 64'(mepc_wen), 64'(r.wen[2]));
        check("mcause_wen", 64'(mcause_wen), 64'(r.wen[1]));
        check("mstatus_wen", 64'(mstatus_wen), 64'(r.wen[0]));
        // disabled ports must read zero
        check("mtvec_wdata", mtvec_wdata, r.wen[3] ? r.wd : 64'd0);
        check("mepc_wdata", mepc_wdata, r.wen[2] ? r.wd : 64'd0);
        check("mcause_wdata", mcause_wdata, r.wen[1] ? r.cause : 64'd0);
        check("mstatus_wdata", mstatus_wdata, r.wen[0] ? r.wd : 64'd0);
    endtask

    initial begin
        int          t;
        int          stall_left;
        bit          got;
        bit          have_snap;
        void'($urandom(29));
        errors = 0;
        out_name = '{"valid_out", "pc_out", "inst_out", "opcode_out", "alu_out",
                     "src_b_out", "dnpc", "pc_update", "mtvec_wen", "mepc_wen",
                     "mcause_wen", "mstatus_wen", "mtvec_wdata", "mepc_wdata",
                     "mcause_wdata", "mstatus_wdata"};
        rst       = 1'b1;
        // an ecall offered while reset is held must not land in the slot
        valid_in  = 1'b1;
        ready_out = 1'b1;
        pc_in     = '0;
        inst_in   = '0;
        opcode_in = `OPC_ECALL;
        src_a     = '0;
        src_b     = '0;
        imm       = '0;
        load_table();
        repeat (2) @(posedge clk);
        #1;
        rst       = 1'b0;
        valid_in  = 1'b0;
        opcode_in = '0;
        // idle slot right after reset
        @(negedge clk);
        check("valid_out", 64'(valid_out), 64'd0);
        check("pc_update", 64'(pc_update), 64'd0);
        check("mtvec_wen", 64'(mtvec_wen), 64'd0);
        check("mepc_wen", 64'(mepc_wen), 64'd0);
        check("mcause_wen", 64'(mcause_wen), 64'd0);
        check("mstatus_wen", 64'(mstatus_wen), 64'd0);

        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            drive_row(rows[i]);
            // wait for the stage to take the row
            t = 0;
            got = 1'b0;
            while (!got) begin
                @(negedge clk);
                // previous row already left so the slot holds a bubble
                check("valid_out", 64'(valid_out), 64'd0);
                got = valid_in && ready_in;
                if (!got) begin
                    t++;
                    if (t > WAIT_LIMIT) begin
                        give_up("input handshake");
                    end
                    @(posedge clk);
                    #1;
                end
            end
            @(posedge clk);
            #1;
            valid_in   = 1'b0;
            // back-pressure of 0 to 3 cycles
            stall_left = $urandom_range(3, 0);
            ready_out  = (stall_left == 0);
            t = 0;
            got = 1'b0;
            have_snap = 1'b0;
            while (!got) begin
                @(negedge clk);
                check("ready_in", 64'(ready_in), 64'(ready_out));
                if (valid_out) begin
                    if (have_snap) begin
                        foreach (cur[k]) begin
                            check(out_name[k], cur[k], held[k]);
                        end
                    end else begin
                        held = cur;
                        have_snap = 1'b1;
                    end
                end
                got = valid_out && ready_out;
                if (!got) begin
                    t++;
                    if (t > WAIT_LIMIT) begin
                        give_up("output handshake");
                    end
                    @(posedge clk);
                    #1;
                    if (stall_left > 0) begin
                        stall_left--;
                    end
                    ready_out = (stall_left == 0);
                end
            end
            check_row(rows[i]);
        end

        // last row drains on this edge
        @(posedge clk);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic               clk,
    input  logic               rst,
    // from decode
    input  logic               valid_in,
    output logic               ready_in,
    input  exu_pkg::xlen_t     pc_in,
    input  exu_pkg::inst_t     inst_in,
    input  exu_pkg::opcode_t   opcode_in,
    input  exu_pkg::xlen_t     src_a,
    input  exu_pkg::xlen_t     src_b,
    input  exu_pkg::xlen_t     imm,
    // to memory stage
    output logic               valid_out,
    input  logic               ready_out,
    output exu_pkg::xlen_t     pc_out,
    output exu_pkg::inst_t     inst_out,
    output exu_pkg::opcode_t   opcode_out,
    output exu_pkg::xlen_t     alu_out,
    output exu_pkg::xlen_t     src_b_out,
    // redirect to fetch
    output exu_pkg::xlen_t     dnpc,
    output logic               pc_update,
    // csr file write ports
    output logic               mtvec_wen,
    output logic               mepc_wen,
    output logic               mcause_wen,
    output logic               mstatus_wen,
    output csr_pkg::csr_data_t mtvec_wdata,
    output csr_pkg::csr_data_t mepc_wdata,
    output csr_pkg::csr_data_t mcause_wdata,
    output csr_pkg::csr_data_t mstatus_wdata
);

    // registered slot, already zeroed when empty
    exu_pkg::xlen_t     slot_src_a;
    exu_pkg::xlen_t     slot_imm;

    // alu inputs
    exu_pkg::alu_mode_t alu_mode;
    exu_pkg::xlen_t     opnd_a;
    exu_pkg::xlen_t     opnd_b;
    exu_pkg::word_sel_t word_sel;

    exu_stage_reg u_stage_reg (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .ready_out (ready_out),
        .pc_in     (pc_in),
        .inst_in   (inst_in),
        .opcode_in (opcode_in),
        .src_a_in  (src_a),
        .src_b_in  (src_b),
        .imm_in    (imm),
        .ready_in  (ready_in),
        .valid     (valid_out),
        .pc        (pc_out),
        .inst      (inst_out),
        .op        (opcode_out),
        .src_a     (slot_src_a),
        .src_b     (src_b_out),
        .imm       (slot_imm)
    );

    exu_operand_sel u_operand_sel (
        .op       (opcode_out),
        .pc       (pc_out),
        .inst     (inst_out),
        .src_a    (slot_src_a),
        .src_b    (src_b_out),
        .imm      (slot_imm),
        .mode     (alu_mode),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b),
        .word_sel (word_sel)
    );

    exu_alu u_alu (
        .mode     (alu_mode),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b),
        .word_sel (word_sel),
        .result   (alu_out)
    );

    // next pc from the same slot, zero cycles
    exu_branch_unit u_branch_unit (
        .op         (opcode_out),
        .pc         (pc_out),
        .src_a      (slot_src_a),
        .src_b      (src_b_out),
        .alu_result (alu_out),
        .dnpc       (dnpc),
        .pc_update  (pc_update)
    );

    exu_csr_ctrl u_csr_ctrl (
        .op            (opcode_out),
        .inst          (inst_out),
        .pc            (pc_out),
        .src_a         (slot_src_a),
        .alu_result    (alu_out),
        .mtvec_wen     (mtvec_wen),
        .mepc_wen      (mepc_wen),
        .mcause_wen    (mcause_wen),
        .mstatus_wen   (mstatus_wen),
        .mtvec_wdata   (mtvec_wdata),
        .mepc_wdata    (mepc_wdata),
        .mcause_wdata  (mcause_wdata),
        .mstatus_wdata (mstatus_wdata)
    );

endmodule

`default_nettype wire

//--- verilog/exu_csr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_csr_ctrl (
    input  exu_pkg::opcode_t   op,
    input  exu_pkg::inst_t     inst,
    input  exu_pkg::xlen_t     pc,
    input  exu_pkg::xlen_t     src_a,
    input  exu_pkg::xlen_t     alu_result,
    output logic               mtvec_wen,
    output logic               mepc_wen,
    output logic               mcause_wen,
    output logic               mstatus_wen,
    output csr_pkg::csr_data_t mtvec_wdata,
    output csr_pkg::csr_data_t mepc_wdata,
    output csr_pkg::csr_data_t mcause_wdata,
    output csr_pkg::csr_data_t mstatus_wdata
);

    csr_pkg::csr_addr_t addr;
    csr_pkg::csr_data_t csr_val;
    logic               is_csr;
    logic               is_ecall;

    // csr number sits in the i-type immediate field
    assign addr     = inst[31:20];
    assign is_csr   = (op == `OPC_CSRRW) || (op == `OPC_CSRRS);
    assign is_ecall = op == `OPC_ECALL;

    // csrrw writes rs1 and csrrs writes old value or rs1 from the alu
    assign csr_val  = (op == `OPC_CSRRW) ? src_a : alu_result;

    assign mtvec_wen   = is_csr && (addr == `CSR_MTVEC);
    assign mstatus_wen = is_csr && (addr == `CSR_MSTATUS);
    // ecall also traps into mepc and mcause
    assign mepc_wen    = (is_csr && (addr == `CSR_MEPC)) || is_ecall;
    assign mcause_wen  = (is_csr && (addr == `CSR_MCAUSE)) || is_ecall;

    // data reads zero whenever its enable is low
    assign mtvec_wdata   = mtvec_wen   ? csr_val : '0;
    assign mstatus_wdata = mstatus_wen ? csr_val : '0;

    always_comb begin
        if (is_ecall) begin
            // faulting pc and the m-mode ecall cause
            mepc_wdata   = pc;
            mcause_wdata = csr_pkg::csr_data_t'(`CAUSE_ECALL_M);
        end else begin
            mepc_wdata   = mepc_wen   ? csr_val : '0;
            mcause_wdata = mcause_wen ? csr_val : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/exu_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_branch_unit (
    input  exu_pkg::opcode_t op,
    input  exu_pkg::xlen_t   pc,
    input  exu_pkg::xlen_t   src_a,
    input  exu_pkg::xlen_t   src_b,
    input  exu_pkg::xlen_t   alu_result,
    output exu_pkg::xlen_t   dnpc,
    output logic             pc_update
);

    exu_pkg::xlen_t snpc;
    logic           eq;
    logic           lt_s;
    logic           lt_u;
    logic           taken;

    // fall-through address
    assign snpc = pc + exu_pkg::xlen_t'(4);

    // branch conditions straight from the register operands
    assign eq   = src_a == src_b;
    assign lt_s = $signed(src_a) < $signed(src_b);
    assign lt_u = src_a < src_b;

    always_comb begin
        case (op)
            `OPC_BEQ:  taken = eq;
            `OPC_BNE:  taken = !eq;
            `OPC_BLT:  taken = lt_s;
            `OPC_BGE:  taken = !lt_s;
            `OPC_BLTU: taken = lt_u;
            `OPC_BGEU: taken = !lt_u;
            default:   taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            `OPC_JAL:  dnpc = alu_result;
            // jalr target has bit 0 dropped
            `OPC_JALR: dnpc = {alu_result[`EXU_XLEN-1:1], 1'b0};
            `OPC_BEQ, `OPC_BNE, `OPC_BLT,
            `OPC_BGE, `OPC_BLTU, `OPC_BGEU: dnpc = taken ? alu_result : snpc;
            // decode puts mtvec or mepc on src_b
            `OPC_ECALL, `OPC_MRET: dnpc = src_b;
            default:   dnpc = snpc;
        endcase

        // not-taken branches still redirect, to snpc
        case (op)
            `OPC_JAL, `OPC_JALR,
            `OPC_BEQ, `OPC_BNE, `OPC_BLT,
            `OPC_BGE, `OPC_BLTU, `OPC_BGEU,
            `OPC_ECALL, `OPC_MRET: pc_update = 1'b1;
            // empty slot reads as op zero and lands here
            default:               pc_update = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_alu (
    input  exu_pkg::alu_mode_t mode,
    input  exu_pkg::xlen_t     opnd_a,
    input  exu_pkg::xlen_t     opnd_b,
    input  exu_pkg::word_sel_t word_sel,
    output exu_pkg::xlen_t     result
);

    localparam int HALF = `EXU_XLEN / 2;
    localparam int SHW  = $clog2(`EXU_XLEN);

    exu_pkg::xlen_t    raw;
    logic [SHW-1:0]    shamt;
    logic              lt_s;
    logic              lt_u;

    assign shamt = opnd_b[SHW-1:0];
    assign lt_s  = $signed(opnd_a) < $signed(opnd_b);
    assign lt_u  = opnd_a < opnd_b;

    always_comb begin
        case (mode)
            `ALU_ADD:  raw = opnd_a + opnd_b;
            `ALU_SUB:  raw = opnd_a - opnd_b;
            // compares give 0 or 1
            `ALU_SLT:  raw = exu_pkg::xlen_t'(lt_s);
            `ALU_SLTU: raw = exu_pkg::xlen_t'(lt_u);
            `ALU_AND:  raw = opnd_a & opnd_b;
            `ALU_OR:   raw = opnd_a | opnd_b;
            `ALU_XOR:  raw = opnd_a ^ opnd_b;
            `ALU_SLL:  raw = opnd_a << shamt;
            `ALU_SRL:  raw = opnd_a >> shamt;
            `ALU_SRA:  raw = exu_pkg::xlen_t'($signed(opnd_a) >>> shamt);
            default:   raw = '0;
        endcase
    end

    // word ops: pick a half and sign-extend it
    always_comb begin
        case (word_sel)
            `WSEL_LO: result = {{HALF{raw[HALF-1]}}, raw[HALF-1:0]};
            // high half is used by the sraiw trick
            `WSEL_HI: result = {{HALF{raw[`EXU_XLEN-1]}}, raw[`EXU_XLEN-1:HALF]};
            default:  result = raw;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exu_operand_sel.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_operand_sel (
    input  exu_pkg::opcode_t   op,
    input  exu_pkg::xlen_t     pc,
    input  exu_pkg::inst_t     inst,
    input  exu_pkg::xlen_t     src_a,
    input  exu_pkg::xlen_t     src_b,
    input  exu_pkg::xlen_t     imm,
    output exu_pkg::alu_mode_t mode,
    output exu_pkg::xlen_t     opnd_a,
    output exu_pkg::xlen_t     opnd_b,
    output exu_pkg::word_sel_t word_sel
);

    localparam int HALF = `EXU_XLEN / 2;

    exu_pkg::xlen_t shamt_w;
    exu_pkg::xlen_t shamt_reg;

    // word shift takes a 5 bit shamt from the instruction
    assign shamt_w   = exu_pkg::xlen_t'(inst[24:20]);
    // register shifts only look at the low 6 bits
    assign shamt_reg = exu_pkg::xlen_t'(src_b[5:0]);

    always_comb begin
        case (op)
            // target address is pc relative
            `OPC_AUIPC, `OPC_JAL,
            `OPC_BEQ, `OPC_BNE, `OPC_BLT,
            `OPC_BGE, `OPC_BLTU, `OPC_BGEU: opnd_a = pc;
            // lui passes imm through the adder
            `OPC_LUI:   opnd_a = '0;
            // word sits in the upper half so sra fills from bit 31
            `OPC_SRAIW: opnd_a = {src_a[HALF-1:0], {HALF{1'b0}}};
            default:    opnd_a = src_a;
        endcase

        case (op)
            `OPC_ADDI, `OPC_LUI, `OPC_AUIPC,
            `OPC_JAL, `OPC_JALR,
            `OPC_BEQ, `OPC_BNE, `OPC_BLT,
            `OPC_BGE, `OPC_BLTU, `OPC_BGEU: opnd_b = imm;
            `OPC_SRAIW:          opnd_b = shamt_w;
            `OPC_SLL, `OPC_SRL:  opnd_b = shamt_reg;
            default:             opnd_b = src_b;
        endcase

        case (op)
            `OPC_ADD, `OPC_ADDW, `OPC_ADDI: mode = `ALU_ADD;
            `OPC_SUB, `OPC_SUBW: mode = `ALU_SUB;
            `OPC_SLL:   mode = `ALU_SLL;
            `OPC_SRL:   mode = `ALU_SRL;
            `OPC_SRAIW: mode = `ALU_SRA;
            `OPC_SLT:   mode = `ALU_SLT;
            `OPC_SLTU:  mode = `ALU_SLTU;
            `OPC_XOR:   mode = `ALU_XOR;
            `OPC_AND:   mode = `ALU_AND;
            // csrrs sets bits, csr value arrives on src_b
            `OPC_OR, `OPC_CSRRS: mode = `ALU_OR;
            // address calc and the rest
            default:    mode = `ALU_ADD;
        endcase

        case (op)
            `OPC_ADDW, `OPC_SUBW: word_sel = `WSEL_LO;
            `OPC_SRAIW:           word_sel = `WSEL_HI;
            default:              word_sel = `WSEL_FULL;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exu_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exu_stage_reg (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_in,
    input  logic             ready_out,
    input  exu_pkg::xlen_t   pc_in,
    input  exu_pkg::inst_t   inst_in,
    input  exu_pkg::opcode_t opcode_in,
    input  exu_pkg::xlen_t   src_a_in,
    input  exu_pkg::xlen_t   src_b_in,
    input  exu_pkg::xlen_t   imm_in,
    output logic             ready_in,
    output logic             valid,
    output exu_pkg::xlen_t   pc,
    output exu_pkg::inst_t   inst,
    output exu_pkg::opcode_t op,
    output exu_pkg::xlen_t   src_a,
    output exu_pkg::xlen_t   src_b,
    output exu_pkg::xlen_t   imm
);

    logic             valid_q;
    exu_pkg::xlen_t   pc_q;
    exu_pkg::inst_t   inst_q;
    exu_pkg::opcode_t op_q;
    exu_pkg::xlen_t   src_a_q;
    exu_pkg::xlen_t   src_b_q;
    exu_pkg::xlen_t   imm_q;

    // single slot, so upstream may push whenever downstream drains
    assign ready_in = ready_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (ready_out) begin
            // bubbles are captured too
            valid_q <= valid_in;
        end
    end

    // payload uses the same enable
    always_ff @(posedge clk) begin
        if (ready_out) begin
            pc_q    <= pc_in;
            inst_q  <= inst_in;
            op_q    <= opcode_in;
            src_a_q <= src_a_in;
            src_b_q <= src_b_in;
            imm_q   <= imm_in;
        end
    end

    // empty slot reads as all zero, op zero decodes to nothing
    assign valid = valid_q;
    assign pc    = valid_q ? pc_q    : '0;
    assign inst  = valid_q ? inst_q  : '0;
    assign op    = valid_q ? op_q    : '0;
    assign src_a = valid_q ? src_a_q : '0;
    assign src_b = valid_q ? src_b_q : '0;
    assign imm   = valid_q ? imm_q   : '0;

    // held slot must look identical on the next edge
    stall_hold_a: assert property (@(posedge clk) disable iff (rst)
        !ready_out |=> $stable(valid) && $stable(pc))
        else $error("slot changed while stalled");

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

`include "exu_settings.svh"

package csr_pkg;

    typedef logic [11:0]          csr_addr_t;
    // value handed to the csr file
    typedef logic [`EXU_XLEN-1:0] csr_data_t;

endpackage

`default_nettype wire

//--- verilog/exu_pkg.sv
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

    // one register or address word
    typedef logic [`EXU_XLEN-1:0]  xlen_t;

    // raw instruction, fields still needed for shamt and csr number
    typedef logic [31:0]           inst_t;

    // decoded operation from the decode stage
    typedef logic [`EXU_OPC_W-1:0] opcode_t;

    typedef logic [3:0]            alu_mode_t;

    // full, low half or high half of the alu word
    typedef logic [1:0]            word_sel_t;

endpackage

`default_nettype wire

//--- verilog/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data path and decoded opcode widths
`define EXU_XLEN        64
`define EXU_OPC_W       24

// one-word opcodes as delivered by decode
`define OPC_LUI         24'h000100
`define OPC_AUIPC       24'h000200
`define OPC_JAL         24'h000300
`define OPC_JALR        24'd4
`define OPC_BEQ         24'd5
`define OPC_BNE         24'd6
`define OPC_BLT         24'd7
`define OPC_BGE         24'd8
`define OPC_BLTU        24'd9
`define OPC_BGEU        24'd10
`define OPC_ADDI        24'd19
`define OPC_CSRRW       24'd49
`define OPC_CSRRS       24'd50
`define OPC_ADD         24'h004000
`define OPC_SUB         24'h005000
`define OPC_SLL         24'h006000
`define OPC_SLT         24'h007000
`define OPC_SLTU        24'h008000
`define OPC_XOR         24'h009000
`define OPC_SRL         24'h010000
`define OPC_OR          24'h012000
`define OPC_AND         24'h013000
`define OPC_SRAIW       24'h016000
`define OPC_ADDW        24'h017000
`define OPC_SUBW        24'h018000
`define OPC_ECALL       24'h200000
`define OPC_MRET        24'h500000

// alu operation selector
`define ALU_ADD         4'd0
`define ALU_SUB         4'd1
`define ALU_SLT         4'd2
`define ALU_SLTU        4'd3
`define ALU_AND         4'd4
`define ALU_OR          4'd6
`define ALU_XOR         4'd7
`define ALU_SLL         4'd8
`define ALU_SRL         4'd9
`define ALU_SRA         4'd10

// result format, full word or one half sign-extended
`define WSEL_FULL       2'd0
`define WSEL_LO         2'd1
`define WSEL_HI         2'd2

// machine csr numbers
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// environment call from m-mode
`define CAUSE_ECALL_M   11

`endif
